// ==== common/rxbuf_pkg.sv ====
/*
 * rxbuf shared types
 * status, configuration and error bundles passed between the FIFO,
 * the flow monitor and the register block, plus register map constants
 */

package rxbuf_pkg;

   // FIFO state as seen by the monitor and the register block
   typedef struct packed {
      logic        full;
      logic        empty;
      logic [15:0] space;
      logic [15:0] occupied;
   } fifo_status_t;

   // pause thresholds, compared against free space
   typedef struct packed {
      logic [15:0] xoff_level;
      logic [15:0] xon_level;
   } flow_cfg_t;

   // sticky misuse flags on the data side
   typedef struct packed {
      logic overflow;
      logic underflow;
   } err_flags_t;

   // register addresses
   localparam logic [1:0] REG_CTRL   = 2'd0;
   localparam logic [1:0] REG_XOFF   = 2'd1;
   localparam logic [1:0] REG_XON    = 2'd2;
   localparam logic [1:0] REG_STATUS = 2'd3;

   // control word bits, each one produces a single cycle pulse
   localparam int CTRL_CLEAR_BIT  = 0;
   localparam int CTRL_ERRCLR_BIT = 1;

endpackage

// ==== longfifo/longfifo.sv ====
/*
 * longfifo
 * block RAM FIFO with first word fall through output, registered full
 * and empty flags, and approximate space and occupied counts
 */

`timescale 1ns/1ps

module longfifo
#(
   parameter int WIDTH = 32,
   parameter int SIZE  = 9
)
(
   input  logic                   clk,
   input  logic                   rst,
   input  logic                   clear,
   input  logic                   write,
   input  logic                   read,
   input  logic [WIDTH-1:0]       din,
   output logic [WIDTH-1:0]       dout,
   output rxbuf_pkg::fifo_status_t status
);

   // read side states
   localparam logic [1:0] EMPTY    = 2'd0;
   localparam logic [1:0] PRE_READ = 2'd1;
   localparam logic [1:0] READING  = 2'd2;

   logic [SIZE-1:0] wr_addr;
   logic [SIZE-1:0] rd_addr;
   logic [1:0]      read_state;
   logic            empty_reg;
   logic            full_reg;
   logic            ram_enb;
   logic [SIZE-1:0] fullness;
   logic [SIZE-1:0] free_space;
   logic [SIZE-1:0] full_guard;
   logic            becoming_full;

   // write pointer
   always_ff @(posedge clk)
   begin
      if (rst || clear)
      begin
         wr_addr <= '0;
      end
      else if (write)
      begin
         wr_addr <= wr_addr + 1'b1;
      end
   end

   // fetch the head word ahead of time so it falls through to dout
   assign ram_enb = (read_state == PRE_READ) | read;

   ram_2port #(
      .WIDTH (WIDTH),
      .SIZE  (SIZE)
   ) ram (
      .clk   (clk),
      .wea   (write),
      .addra (wr_addr),
      .dia   (din),
      .enb   (ram_enb),
      .addrb (rd_addr),
      .dob   (dout)
   );

   // read state machine
   // rd_addr runs one ahead of the words popped while data is shown
   always_ff @(posedge clk)
   begin
      if (rst || clear)
      begin
         read_state <= EMPTY;
         rd_addr    <= '0;
         empty_reg  <= 1'b1;
      end
      else
      begin
         case (read_state)
            EMPTY:
            begin
               if (write)
               begin
                  read_state <= PRE_READ;
               end
            end
            PRE_READ:
            begin
               read_state <= READING;
               empty_reg  <= 1'b0;
               rd_addr    <= rd_addr + 1'b1;
            end
            READING:
            begin
               if (read)
               begin
                  if (rd_addr == wr_addr)
                  begin
                     // last word popped
                     empty_reg  <= 1'b1;
                     read_state <= write ? PRE_READ : EMPTY;
                  end
                  else
                  begin
                     rd_addr <= rd_addr + 1'b1;
                  end
               end
            end
            default:
            begin
               read_state <= EMPTY;
            end
         endcase
      end
   end

   // full keeps three slots of margin behind the read pointer
   assign full_guard    = rd_addr - 2'd3;
   assign becoming_full = (wr_addr == full_guard);

   always_ff @(posedge clk)
   begin
      if (rst || clear)
      begin
         full_reg <= 1'b0;
      end
      else if (read && !write)
      begin
         full_reg <= 1'b0;
      end
      else if (write && !read && becoming_full)
      begin
         full_reg <= 1'b1;
      end
   end

   // counts are approximate, good enough for flow control
   assign fullness   = wr_addr - rd_addr;
   assign free_space = rd_addr - wr_addr - 2'd2;

   assign status.full     = full_reg;
   assign status.empty    = empty_reg;
   assign status.space    = {{(16-SIZE){1'b0}}, free_space};
   assign status.occupied = {{(16-SIZE){1'b0}}, fullness};

endmodule

// ==== longfifo/ram_2port.sv ====
/*
 * ram_2port
 * simple dual port block RAM, port A writes and port B reads
 */

`timescale 1ns/1ps

module ram_2port
#(
   parameter int WIDTH = 32,
   parameter int SIZE  = 9
)
(
   input  logic             clk,

   input  logic             wea,
   input  logic [SIZE-1:0]  addra,
   input  logic [WIDTH-1:0] dia,

   input  logic             enb,
   input  logic [SIZE-1:0]  addrb,
   output logic [WIDTH-1:0] dob
);

   localparam int DEPTH = 2 ** SIZE;

   logic [WIDTH-1:0] mem [0:DEPTH-1];

   // write port
   always_ff @(posedge clk)
   begin
      if (wea)
      begin
         mem[addra] <= dia;
      end
   end

   // registered read, output holds while enb is low
   always_ff @(posedge clk)
   begin
      if (enb)
      begin
         dob <= mem[addrb];
      end
   end

endmodule

// ==== tb.f ====
common/rxbuf_pkg.sv
longfifo/ram_2port.sv
longfifo/longfifo.sv
verilog/flow_monitor.sv
verilog/rxbuf_regs.sv
verilog/rxbuf_top.sv
tb/rxbuf_tb.sv

// ==== tb/rxbuf_tb.sv ====
/*
 * rxbuf testbench
 * random traffic from an LFSR against a queue and pointer model of the
 * receive buffer, with pause, sticky error and clear checks
 */

`timescale 1ns/1ps

module rxbuf_tb;

   localparam int WIDTH = 32;
   localparam int SIZE  = 6;
   localparam int DEPTH = 2 ** SIZE;

   logic             clk;
   logic             rst;
   logic [WIDTH-1:0] din;
   logic             write;
   logic             read;
   logic [WIDTH-1:0] dout;
   logic             full;
   logic             empty;
   logic             pause;
   logic             reg_wr;
   logic             reg_rd;
   logic [1:0]       reg_addr;
   logic [15:0]      reg_wdata;
   logic [15:0]      reg_rdata;

   // reference model state
   logic [WIDTH-1:0] q[$];
   int               wcnt;
   int               rcnt;
   int               st;
   logic             m_empty, m_full, m_pause, m_ovf, m_unf, m_clr, m_eclr;
   logic [15:0]      m_xoff, m_xon;
   logic             rd_pending;
   logic             rd_is_count;
   logic [15:0]      exp_rdata;
   logic             saw_pause;
   logic [15:0]      lfsr;

   rxbuf_top #(.WIDTH(WIDTH), .SIZE(SIZE)) uut (
      .clk(clk), .rst(rst), .din(din), .write(write), .read(read),
      .dout(dout), .full(full), .empty(empty), .pause(pause),
      .reg_wr(reg_wr), .reg_rd(reg_rd), .reg_addr(reg_addr),
      .reg_wdata(reg_wdata), .reg_rdata(reg_rdata)
   );

   initial
   begin
      clk = 1'b0;
      forever #20 clk = ~clk;
   end

   // x^16 + x^14 + x^13 + x^11 + 1, one step per bit taken
   function automatic logic [31:0] rand_bits(input int n);
      logic [31:0] r;
      logic        b;
      r = '0;
      for (int i = 0; i < n; i++)
      begin
         b    = lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10];
         lfsr = {lfsr[14:0], b};
         r    = {r[30:0], b};
      end
      return r;
   endfunction

   task automatic report_fail(input string msg);
      $display("[FAIL] %0t ns: %s", $time, msg);
      $display("ERRORS FOUND");
      $fatal(1, "stopped at first error");
   endtask

   task automatic abort_on_timeout(input string what);
      $display("timed out waiting for %s", what);
      $display("ERRORS FOUND");
      $fatal(1, "stopped on timeout");
   endtask

   task automatic check_word(input string name, input logic [WIDTH-1:0] got,
                             input logic [WIDTH-1:0] exp);
      if (got !== exp)
         report_fail($sformatf("%s got %h expected %h", name, got, exp));
   endtask

   task automatic check_flag(input string name, input logic got, input logic exp);
      if (got !== exp)
         report_fail($sformatf("%s got %b expected %b", name, got, exp));
   endtask

   task automatic check_count(input string name, input logic [15:0] got,
                              input logic [15:0] exp);
      if (got !== exp)
         report_fail($sformatf("%s got %0d expected %0d", name, got, exp));
   endtask

   task automatic check_reg(input string name, input logic [15:0] got,
                            input logic [15:0] exp);
      if (got !== exp)
         report_fail($sformatf("%s got %h expected %h", name, got, exp));
   endtask

   // next state of the model from the inputs applied at the coming edge
   task automatic advance_model(input logic w, input logic r, input logic [WIDTH-1:0] d,
                                input logic rw, input logic rr, input logic [1:0] ra,
                                input logic [15:0] rwd);
      logic [SIZE-1:0] wp, rp, sp6, oc6;
      logic [15:0]     sp, oc;
      logic            p_empty, p_full, p_clr, p_eclr;
      logic [15:0]     p_xoff, p_xon, stat;
      wp      = wcnt;
      rp      = rcnt + (m_empty ? 0 : 1);
      sp6     = rp - wp - 2;
      oc6     = wp - rp;
      sp      = {{(16-SIZE){1'b0}}, sp6};
      oc      = {{(16-SIZE){1'b0}}, oc6};
      p_empty = m_empty;
      p_full  = m_full;
      p_clr   = m_clr;
      p_eclr  = m_eclr;
      p_xoff  = m_xoff;
      p_xon   = m_xon;
      stat    = {11'd0, m_empty, m_full, m_unf, m_ovf, m_pause};

      rd_pending  = rr;
      rd_is_count = (ra == rxbuf_pkg::REG_CTRL);
      if (rr)
      begin
         case (ra)
            rxbuf_pkg::REG_CTRL: exp_rdata = oc;
            rxbuf_pkg::REG_XOFF: exp_rdata = p_xoff;
            rxbuf_pkg::REG_XON:  exp_rdata = p_xon;
            default:             exp_rdata = stat;
         endcase
      end

      m_clr  = rw && (ra == rxbuf_pkg::REG_CTRL) && rwd[rxbuf_pkg::CTRL_CLEAR_BIT];
      m_eclr = rw && (ra == rxbuf_pkg::REG_CTRL) && rwd[rxbuf_pkg::CTRL_ERRCLR_BIT];
      if (rw && ra == rxbuf_pkg::REG_XOFF)
         m_xoff = rwd;
      if (rw && ra == rxbuf_pkg::REG_XON)
         m_xon = rwd;

      if (sp < p_xoff)
         m_pause = 1'b1;
      else if (sp >= p_xon)
         m_pause = 1'b0;

      if (p_eclr)
      begin
         m_ovf = 1'b0;
         m_unf = 1'b0;
      end
      else
      begin
         if (w && p_full)
            m_ovf = 1'b1;
         if (r && p_empty)
            m_unf = 1'b1;
      end

      if (p_clr)
      begin
         st      = 0;
         m_empty = 1'b1;
         m_full  = 1'b0;
         wcnt    = 0;
         rcnt    = 0;
         q.delete();
      end
      else
      begin
         // full rises on a write-only cycle with depth minus 3 occupied
         if (r && !w)
            m_full = 1'b0;
         else if (w && !r && oc6 == DEPTH - 3)
            m_full = 1'b1;
         // EMPTY, PRE_READ, READING
         case (st)
            0: if (w) st = 1;
            1:
            begin
               st      = 2;
               m_empty = 1'b0;
            end
            default:
            begin
               if (r && rp == wp)
               begin
                  m_empty = 1'b1;
                  st      = w ? 1 : 0;
               end
            end
         endcase
         if (r && !p_empty)
         begin
            void'(q.pop_front());
            rcnt++;
         end
         if (w)
         begin
            q.push_back(d);
            wcnt++;
         end
      end
   endtask

   // outputs settle after the rising edge and are compared on the falling one
   task automatic sample_outputs();
      @(negedge clk);
      check_flag("empty", empty, m_empty);
      check_flag("full", full, m_full);
      check_flag("pause", pause, m_pause);
      if (!m_empty)
         check_word("dout", dout, q[0]);
      if (rd_pending && rd_is_count)
         check_count("occupied", reg_rdata, exp_rdata);
      else if (rd_pending)
         check_reg("reg_rdata", reg_rdata, exp_rdata);
      if (m_pause)
         saw_pause = 1'b1;
   endtask

   task automatic drive_inputs(input logic w, input logic r, input logic [WIDTH-1:0] d,
                               input logic rw, input logic rr, input logic [1:0] ra,
                               input logic [15:0] rwd);
      rst       = 1'b0;
      write     = w;
      read      = r;
      din       = d;
      reg_wr    = rw;
      reg_rd    = rr;
      reg_addr  = ra;
      reg_wdata = rwd;
      advance_model(w, r, d, rw, rr, ra, rwd);
   endtask

   // check the state after the last edge, then drive the next cycle
   task automatic run_cycle(input logic w, input logic r, input logic [WIDTH-1:0] d,
                            input logic rw, input logic rr, input logic [1:0] ra,
                            input logic [15:0] rwd);
      sample_outputs();
      drive_inputs(w, r, d, rw, rr, ra, rwd);
   endtask

   task automatic idle_cycle();
      run_cycle(1'b0, 1'b0, '0, 1'b0, 1'b0, 2'd0, 16'd0);
   endtask

   task automatic write_reg(input logic [1:0] a, input logic [15:0] v);
      run_cycle(1'b0, 1'b0, '0, 1'b1, 1'b0, a, v);
   endtask

   task automatic read_reg(input logic [1:0] a);
      run_cycle(1'b0, 1'b0, '0, 1'b0, 1'b1, a, 16'd0);
      idle_cycle();
   endtask

   task automatic random_traffic(input int n);
      logic [31:0]      wb, rb;
      logic [WIDTH-1:0] d;
      for (int i = 0; i < n; i++)
      begin
         wb = rand_bits(1);
         rb = rand_bits(1);
         d  = rand_bits(WIDTH);
         sample_outputs();
         drive_inputs(wb[0] && !full, rb[0] && !empty, d, 1'b0, 1'b0, 2'd0, 16'd0);
      end
   endtask

   task automatic fill_until_full();
      int n;
      n = 0;
      sample_outputs();
      while (!full)
      begin
         if (n > 2 * DEPTH)
            abort_on_timeout("full to rise");
         drive_inputs(1'b1, 1'b0, rand_bits(WIDTH), 1'b0, 1'b0, 2'd0, 16'd0);
         sample_outputs();
         n++;
      end
      drive_inputs(1'b0, 1'b0, '0, 1'b0, 1'b0, 2'd0, 16'd0);
   endtask

   task automatic drain_until_empty();
      int n;
      n = 0;
      sample_outputs();
      while (q.size() > 0 || !empty)
      begin
         if (n > 4 * DEPTH)
            abort_on_timeout("the FIFO to drain");
         drive_inputs(1'b0, !empty, '0, 1'b0, 1'b0, 2'd0, 16'd0);
         sample_outputs();
         n++;
      end
      drive_inputs(1'b0, 1'b0, '0, 1'b0, 1'b0, 2'd0, 16'd0);
      read_reg(rxbuf_pkg::REG_CTRL);
   endtask

   task automatic wait_empty_low();
      int n;
      n = 0;
      while (empty)
      begin
         if (n > 8)
            abort_on_timeout("empty to fall");
         idle_cycle();
         n++;
      end
   endtask

   initial
   begin
      lfsr      = 16'd18516;
      rst       = 1'b1;
      din       = '0;
      write     = 1'b0;
      read      = 1'b0;
      reg_wr    = 1'b0;
      reg_rd    = 1'b0;
      reg_addr  = 2'd0;
      reg_wdata = 16'd0;
      wcnt      = 0;
      rcnt      = 0;
      st        = 0;
      m_empty   = 1'b1;
      m_full    = 1'b0;
      m_pause   = 1'b0;
      m_ovf     = 1'b0;
      m_unf     = 1'b0;
      m_clr     = 1'b0;
      m_eclr    = 1'b0;
      m_xoff    = 16'd16;
      m_xon     = 16'd32;
      rd_pending  = 1'b0;
      rd_is_count = 1'b0;
      exp_rdata   = 16'd0;
      saw_pause   = 1'b0;
      repeat (2) @(posedge clk);

      // fall through from empty, then random order checks
      run_cycle(1'b1, 1'b0, rand_bits(WIDTH), 1'b0, 1'b0, 2'd0, 16'd0);
      wait_empty_low();
      random_traffic(400);
      drain_until_empty();

      // fill and drain with default levels
      fill_until_full();
      drain_until_empty();

      // pause hysteresis with programmed levels
      write_reg(rxbuf_pkg::REG_XOFF, 16'd20);
      write_reg(rxbuf_pkg::REG_XON, 16'd40);
      read_reg(rxbuf_pkg::REG_XOFF);
      read_reg(rxbuf_pkg::REG_XON);
      saw_pause = 1'b0;
      fill_until_full();
      drain_until_empty();
      if (!saw_pause)
         abort_on_timeout("pause to be raised during the fill");

      // sticky errors survive until cleared
      idle_cycle();
      run_cycle(1'b0, 1'b1, '0, 1'b0, 1'b0, 2'd0, 16'd0);
      fill_until_full();
      run_cycle(1'b1, 1'b0, rand_bits(WIDTH), 1'b0, 1'b0, 2'd0, 16'd0);
      read_reg(rxbuf_pkg::REG_STATUS);
      repeat (3) idle_cycle();
      read_reg(rxbuf_pkg::REG_STATUS);
      write_reg(rxbuf_pkg::REG_CTRL, 16'd1 << rxbuf_pkg::CTRL_ERRCLR_BIT);
      idle_cycle();
      read_reg(rxbuf_pkg::REG_STATUS);

      // clear with data stored, then fresh traffic
      write_reg(rxbuf_pkg::REG_CTRL, 16'd1 << rxbuf_pkg::CTRL_CLEAR_BIT);
      repeat (3) idle_cycle();
      read_reg(rxbuf_pkg::REG_STATUS);
      random_traffic(200);
      drain_until_empty();
      idle_cycle();

      $display("NO ERRORS");
      $finish;
   end

endmodule

// ==== verilog/flow_monitor.sv ====
/*
 * flow_monitor
 * drives the link pause level with hysteresis on FIFO free space and
 * latches sticky overflow and underflow flags
 */

`timescale 1ns/1ps

module flow_monitor
(
   input  logic                    clk,
   input  logic                    rst,
   input  logic                    err_clear,
   input  logic                    write,
   input  logic                    read,
   input  rxbuf_pkg::fifo_status_t status,
   input  rxbuf_pkg::flow_cfg_t    cfg,
   output logic                    pause,
   output rxbuf_pkg::err_flags_t   errors
);

   // pause (XOFF) when space drops below xoff, release (XON) once
   // space recovers to xon, hold in between
   always_ff @(posedge clk)
   begin
      if (rst)
      begin
         pause <= 1'b0;
      end
      else if (status.space < cfg.xoff_level)
      begin
         pause <= 1'b1;
      end
      else if (status.space >= cfg.xon_level)
      begin
         pause <= 1'b0;
      end
   end

   // sticky misuse flags, cleared only from the control register
   always_ff @(posedge clk)
   begin
      if (rst || err_clear)
      begin
         errors.overflow  <= 1'b0;
         errors.underflow <= 1'b0;
      end
      else
      begin
         if (write && status.full)
         begin
            errors.overflow <= 1'b1;
         end
         if (read && status.empty)
         begin
            errors.underflow <= 1'b1;
         end
      end
   end

endmodule

// ==== verilog/rxbuf_regs.sv ====
/*
 * rxbuf_regs
 * strobe driven register block with the pause levels, control pulses
 * and a registered status readback
 */

`timescale 1ns/1ps

module rxbuf_regs
(
   input  logic                    clk,
   input  logic                    rst,
   input  logic                    reg_wr,
   input  logic                    reg_rd,
   input  logic [1:0]              reg_addr,
   input  logic [15:0]             reg_wdata,
   output logic [15:0]             reg_rdata,
   input  logic                    pause,
   input  rxbuf_pkg::fifo_status_t status,
   input  rxbuf_pkg::err_flags_t   errors,
   output rxbuf_pkg::flow_cfg_t    cfg,
   output logic                    fifo_clear,
   output logic                    err_clear
);

   localparam logic [15:0] XOFF_RESET = 16'd16;
   localparam logic [15:0] XON_RESET  = 16'd32;

   logic        ctrl_wr;
   logic [15:0] status_word;

   assign ctrl_wr = reg_wr && (reg_addr == rxbuf_pkg::REG_CTRL);

   // level registers
   always_ff @(posedge clk)
   begin
      if (rst)
      begin
         cfg.xoff_level <= XOFF_RESET;
         cfg.xon_level  <= XON_RESET;
      end
      else if (reg_wr)
      begin
         if (reg_addr == rxbuf_pkg::REG_XOFF)
         begin
            cfg.xoff_level <= reg_wdata;
         end
         if (reg_addr == rxbuf_pkg::REG_XON)
         begin
            cfg.xon_level <= reg_wdata;
         end
      end
   end

   // control bits are pulses, never stored
   always_ff @(posedge clk)
   begin
      if (rst)
      begin
         fifo_clear <= 1'b0;
         err_clear  <= 1'b0;
      end
      else
      begin
         fifo_clear <= ctrl_wr && reg_wdata[rxbuf_pkg::CTRL_CLEAR_BIT];
         err_clear  <= ctrl_wr && reg_wdata[rxbuf_pkg::CTRL_ERRCLR_BIT];
      end
   end

   // status word, bit 0 upward: pause, overflow, underflow, full, empty
   assign status_word = {11'd0,
                         status.empty,
                         status.full,
                         errors.underflow,
                         errors.overflow,
                         pause};

   // readback, data valid the cycle after the strobe
   always_ff @(posedge clk)
   begin
      if (reg_rd)
      begin
         case (reg_addr)
            rxbuf_pkg::REG_CTRL:   reg_rdata <= status.occupied;
            rxbuf_pkg::REG_XOFF:   reg_rdata <= cfg.xoff_level;
            rxbuf_pkg::REG_XON:    reg_rdata <= cfg.xon_level;
            rxbuf_pkg::REG_STATUS: reg_rdata <= status_word;
            default:               reg_rdata <= status_word;
         endcase
      end
   end

endmodule

// ==== verilog/rxbuf_top.sv ====
/*
 * rxbuf_top
 * serial link receive buffer: FIFO, pause monitor and register block
 */

`timescale 1ns/1ps

module rxbuf_top
#(
   parameter int WIDTH = 32,
   parameter int SIZE  = 9
)
(
   input  logic             clk,
   input  logic             rst,

   // data side
   input  logic [WIDTH-1:0] din,
   input  logic             write,
   input  logic             read,
   output logic [WIDTH-1:0] dout,
   output logic             full,
   output logic             empty,

   // link flow control
   output logic             pause,

   // register side
   input  logic             reg_wr,
   input  logic             reg_rd,
   input  logic [1:0]       reg_addr,
   input  logic [15:0]      reg_wdata,
   output logic [15:0]      reg_rdata
);

   rxbuf_pkg::fifo_status_t fifo_status;
   rxbuf_pkg::flow_cfg_t    flow_cfg;
   rxbuf_pkg::err_flags_t   err_flags;
   logic                    fifo_clear;
   logic                    err_clear;

   assign full  = fifo_status.full;
   assign empty = fifo_status.empty;

   longfifo #(
      .WIDTH (WIDTH),
      .SIZE  (SIZE)
   ) fifo (
      .clk    (clk),
      .rst    (rst),
      .clear  (fifo_clear),
      .write  (write),
      .read   (read),
      .din    (din),
      .dout   (dout),
      .status (fifo_status)
   );

   flow_monitor monitor (
      .clk       (clk),
      .rst       (rst),
      .err_clear (err_clear),
      .write     (write),
      .read      (read),
      .status    (fifo_status),
      .cfg       (flow_cfg),
      .pause     (pause),
      .errors    (err_flags)
   );

   rxbuf_regs regs (
      .clk        (clk),
      .rst        (rst),
      .reg_wr     (reg_wr),
      .reg_rd     (reg_rd),
      .reg_addr   (reg_addr),
      .reg_wdata  (reg_wdata),
      .reg_rdata  (reg_rdata),
      .pause      (pause),
      .status     (fifo_status),
      .errors     (err_flags),
      .cfg        (flow_cfg),
      .fifo_clear (fifo_clear),
      .err_clear  (err_clear)
   );

endmodule
